// File: verilog/streamer_pkg.sv
package streamer_pkg;

  // word widths shared by the memory port and the streams
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 16;  // word address
  localparam int unsigned LEN_W  = 16;  // job length and beat counters

  // load buffer entries, also the cap on reads in flight plus words held
  localparam int unsigned LOAD_FIFO_DEPTH = 4;

  // pointer wrap relies on a power-of-two depth
  localparam int unsigned LOAD_PTR_W = $clog2(LOAD_FIFO_DEPTH);
  localparam int unsigned LOAD_CNT_W = $clog2(LOAD_FIFO_DEPTH + 1);

  // job opcodes
  // the four loads pick the output stream, the store drains the input stream
  typedef enum logic [2:0] {
    OP_LD_FEAT     = 3'd0,
    OP_LD_WEIGHT   = 3'd1,
    OP_LD_NORM     = 3'd2,
    OP_LD_STREAMIN = 3'd3,
    OP_ST_OUT      = 3'd4
  } streamer_op_e;

endpackage

// File: verilog/mem_if.sv
`timescale 1ns/10ps

interface mem_if;
  import streamer_pkg::*;

  // request channel
  logic              req;
  logic              wen;   // 1 means write
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic              gnt;

  // response channel, one beat per granted read
  logic [DATA_W-1:0] rdata;
  logic              r_valid;

  modport req_mp (
    output req,
    output wen,
    output addr,
    output wdata,
    input  gnt
  );

  modport rsp_mp (
    input rdata,
    input r_valid
  );

endinterface

// File: verilog/streamer_ctrl.sv
`timescale 1ns/10ps

module streamer_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // job request
  input  logic                             start_i,
  input  streamer_pkg::streamer_op_e       op_i,
  input  logic [streamer_pkg::ADDR_W-1:0]  base_i,
  input  logic [streamer_pkg::ADDR_W-1:0]  stride_i,
  input  logic [streamer_pkg::LEN_W-1:0]   len_i,
  // completed beats from the datapath
  input  logic                             ld_beat_i,
  input  logic                             st_beat_i,
  // status and registered job
  output logic                             run_o,
  output logic                             is_store_o,
  output logic                             busy_o,
  output logic                             done_o,
  output streamer_pkg::streamer_op_e       op_o,
  output logic [streamer_pkg::ADDR_W-1:0]  base_o,
  output logic [streamer_pkg::ADDR_W-1:0]  stride_o,
  output logic [streamer_pkg::LEN_W-1:0]   len_o
);
  import streamer_pkg::*;

  typedef enum logic [1:0] {IDLE, RUN, DONE} state_e;

  state_e           state_q, state_d;
  streamer_op_e     op_q;
  logic [ADDR_W-1:0] base_q, stride_q;
  logic [LEN_W-1:0]  len_q;
  logic [LEN_W-1:0]  beat_cnt_q;
  logic             accept;
  logic             beat;
  logic             last_beat;

  // a start is only taken while not busy, DONE counts as not busy
  assign accept    = start_i && (state_q != RUN);
  assign beat      = is_store_o ? st_beat_i : ld_beat_i;
  assign last_beat = beat && (beat_cnt_q == len_q - 1'b1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_i) state_d = RUN;
      RUN:     if (last_beat) state_d = DONE;
      DONE:    state_d = start_i ? RUN : IDLE;  // back-to-back job
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      op_q       <= OP_LD_FEAT;
      beat_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        op_q       <= op_i;
        beat_cnt_q <= '0;
      end else if (state_q == RUN && beat) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  // job payload, only meaningful while running
  always_ff @(posedge clk_i) begin
    if (accept) begin
      base_q   <= base_i;
      stride_q <= stride_i;
      len_q    <= len_i;
    end
  end

  assign run_o      = (state_q == RUN);
  assign busy_o     = (state_q == RUN);
  assign done_o     = (state_q == DONE);  // one cycle, then IDLE or RUN
  assign is_store_o = (op_q == OP_ST_OUT);
  assign op_o       = op_q;
  assign base_o     = base_q;
  assign stride_o   = stride_q;
  assign len_o      = len_q;

endmodule

// File: verilog/req_gen.sv
`timescale 1ns/10ps

module req_gen (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // job from the controller
  input  logic                             run_i,
  input  logic                             is_store_i,
  input  logic [streamer_pkg::ADDR_W-1:0]  base_i,
  input  logic [streamer_pkg::ADDR_W-1:0]  stride_i,
  input  logic [streamer_pkg::LEN_W-1:0]   len_i,
  // read credit from the load buffer
  input  logic                             credit_ok_i,
  // store stream in
  input  logic                             st_valid_i,
  input  logic [streamer_pkg::DATA_W-1:0]  st_data_i,
  output logic                             st_ready_o,
  output logic                             st_beat_o,
  // memory request side
  mem_if.req_mp                            mem
);
  import streamer_pkg::*;

  logic              run_q;
  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  issued_q;
  logic [ADDR_W-1:0] cur_addr;
  logic [LEN_W-1:0]  cur_issued;
  logic              req;
  logic              fire;
  logic              src_ok;

  // first cycle of a job works from base directly so the first
  // request can go out together with busy
  assign cur_addr   = run_q ? addr_q : base_i;
  assign cur_issued = run_q ? issued_q : '0;

  // stores need a word to write, loads need room for the response
  assign src_ok = is_store_i ? st_valid_i : credit_ok_i;
  assign req    = run_i && (cur_issued < len_i) && src_ok;
  assign fire   = req && mem.gnt;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      run_q    <= 1'b0;
      issued_q <= '0;
    end else begin
      run_q    <= run_i;
      issued_q <= cur_issued + LEN_W'(fire);
    end
  end

  // next address of the strided pattern after each grant
  always_ff @(posedge clk_i) begin
    addr_q <= fire ? cur_addr + stride_i : cur_addr;
  end

  assign mem.req   = req;
  assign mem.wen   = is_store_i;
  assign mem.addr  = cur_addr;
  assign mem.wdata = st_data_i;  // only looked at on writes

  // the store word is consumed by the write grant
  assign st_ready_o = fire && is_store_i;
  assign st_beat_o  = st_ready_o && st_valid_i;

endmodule

// File: verilog/load_buffer.sv
`timescale 1ns/10ps

module load_buffer (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             run_i,
  input  streamer_pkg::streamer_op_e       op_i,
  // memory responses
  mem_if.rsp_mp                            mem,
  input  logic                             req_fire_i,  // granted read
  output logic                             credit_ok_o,
  output logic                             ld_beat_o,
  // load streams out
  output logic                             feat_valid_o,
  output logic [streamer_pkg::DATA_W-1:0]  feat_data_o,
  input  logic                             feat_ready_i,
  output logic                             weight_valid_o,
  output logic [streamer_pkg::DATA_W-1:0]  weight_data_o,
  input  logic                             weight_ready_i,
  output logic                             norm_valid_o,
  output logic [streamer_pkg::DATA_W-1:0]  norm_data_o,
  input  logic                             norm_ready_i,
  output logic                             streamin_valid_o,
  output logic [streamer_pkg::DATA_W-1:0]  streamin_data_o,
  input  logic                             streamin_ready_i
);
  import streamer_pkg::*;

  logic [DATA_W-1:0]     fifo_mem [LOAD_FIFO_DEPTH];
  logic [LOAD_PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [LOAD_CNT_W-1:0] fill_q;   // words held
  logic [LOAD_CNT_W-1:0] outst_q;  // reads granted, data not back yet
  logic [LOAD_CNT_W:0]   used;
  logic [DATA_W-1:0]     head;
  logic [3:0]            sel_vec;
  logic [3:0]            ready_vec;
  logic                  head_valid;
  logic                  push;
  logic                  pop;

  // one-hot stream select, a store selects none
  always_comb begin
    sel_vec = '0;
    case (op_i)
      OP_LD_FEAT:     sel_vec[0] = 1'b1;
      OP_LD_WEIGHT:   sel_vec[1] = 1'b1;
      OP_LD_NORM:     sel_vec[2] = 1'b1;
      OP_LD_STREAMIN: sel_vec[3] = 1'b1;
      default:        sel_vec = '0;
    endcase
  end

  assign ready_vec  = {streamin_ready_i, norm_ready_i, weight_ready_i, feat_ready_i};
  assign head       = fifo_mem[rd_ptr_q];
  assign head_valid = run_i && (fill_q != '0);
  assign push       = mem.r_valid;  // responses cannot wait
  assign pop        = head_valid && |(sel_vec & ready_vec);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
      outst_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      fill_q  <= fill_q + LOAD_CNT_W'(push) - LOAD_CNT_W'(pop);
      outst_q <= outst_q + LOAD_CNT_W'(req_fire_i) - LOAD_CNT_W'(push);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) fifo_mem[wr_ptr_q] <= mem.rdata;
  end

  // every read in flight already owns an entry, so no overflow
  assign used        = outst_q + fill_q;
  assign credit_ok_o = (used < LOAD_FIFO_DEPTH);
  assign ld_beat_o   = pop;

  assign feat_valid_o     = head_valid && sel_vec[0];
  assign weight_valid_o   = head_valid && sel_vec[1];
  assign norm_valid_o     = head_valid && sel_vec[2];
  assign streamin_valid_o = head_valid && sel_vec[3];

  assign feat_data_o     = sel_vec[0] ? head : '0;
  assign weight_data_o   = sel_vec[1] ? head : '0;
  assign norm_data_o     = sel_vec[2] ? head : '0;
  assign streamin_data_o = sel_vec[3] ? head : '0;

endmodule

// File: verilog/streamer_top.sv
`timescale 1ns/10ps

module streamer_top (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // job
  input  logic                             start_i,
  input  streamer_pkg::streamer_op_e       op_i,
  input  logic [streamer_pkg::ADDR_W-1:0]  base_i,
  input  logic [streamer_pkg::ADDR_W-1:0]  stride_i,
  input  logic [streamer_pkg::LEN_W-1:0]   len_i,
  output logic                             busy_o,
  output logic                             done_o,
  // memory port
  output logic                             mem_req_o,
  output logic                             mem_wen_o,
  output logic [streamer_pkg::ADDR_W-1:0]  mem_addr_o,
  output logic [streamer_pkg::DATA_W-1:0]  mem_wdata_o,
  input  logic                             mem_gnt_i,
  input  logic [streamer_pkg::DATA_W-1:0]  mem_rdata_i,
  input  logic                             mem_rvalid_i,
  // store stream in
  input  logic                             st_valid_i,
  input  logic [streamer_pkg::DATA_W-1:0]  st_data_i,
  output logic                             st_ready_o,
  // load streams out
  output logic                             feat_valid_o,
  output logic [streamer_pkg::DATA_W-1:0]  feat_data_o,
  input  logic                             feat_ready_i,
  output logic                             weight_valid_o,
  output logic [streamer_pkg::DATA_W-1:0]  weight_data_o,
  input  logic                             weight_ready_i,
  output logic                             norm_valid_o,
  output logic [streamer_pkg::DATA_W-1:0]  norm_data_o,
  input  logic                             norm_ready_i,
  output logic                             streamin_valid_o,
  output logic [streamer_pkg::DATA_W-1:0]  streamin_data_o,
  input  logic                             streamin_ready_i
);
  import streamer_pkg::*;

  logic              run, is_store;
  logic              ld_beat, st_beat;
  logic              credit_ok, req_fire;
  streamer_op_e      job_op;
  logic [ADDR_W-1:0] job_base, job_stride;
  logic [LEN_W-1:0]  job_len;

  mem_if mem_bus ();

  assign mem_req_o       = mem_bus.req;
  assign mem_wen_o       = mem_bus.wen;
  assign mem_addr_o      = mem_bus.addr;
  assign mem_wdata_o     = mem_bus.wdata;
  assign mem_bus.gnt     = mem_gnt_i;
  assign mem_bus.rdata   = mem_rdata_i;
  assign mem_bus.r_valid = mem_rvalid_i;

  assign req_fire = mem_bus.req && mem_bus.gnt && !mem_bus.wen;  // granted read

  streamer_ctrl i_ctrl (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .start_i    ( start_i    ),
    .op_i       ( op_i       ),
    .base_i     ( base_i     ),
    .stride_i   ( stride_i   ),
    .len_i      ( len_i      ),
    .ld_beat_i  ( ld_beat    ),
    .st_beat_i  ( st_beat    ),
    .run_o      ( run        ),
    .is_store_o ( is_store   ),
    .busy_o     ( busy_o     ),
    .done_o     ( done_o     ),
    .op_o       ( job_op     ),
    .base_o     ( job_base   ),
    .stride_o   ( job_stride ),
    .len_o      ( job_len    )
  );

  req_gen i_req_gen (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .run_i       ( run         ),
    .is_store_i  ( is_store    ),
    .base_i      ( job_base    ),
    .stride_i    ( job_stride  ),
    .len_i       ( job_len     ),
    .credit_ok_i ( credit_ok   ),
    .st_valid_i  ( st_valid_i  ),
    .st_data_i   ( st_data_i   ),
    .st_ready_o  ( st_ready_o  ),
    .st_beat_o   ( st_beat     ),
    .mem         ( mem_bus     )
  );

  load_buffer i_load_buffer (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .run_i            ( run              ),
    .op_i             ( job_op           ),
    .mem              ( mem_bus          ),
    .req_fire_i       ( req_fire         ),
    .credit_ok_o      ( credit_ok        ),
    .ld_beat_o        ( ld_beat          ),
    .feat_valid_o     ( feat_valid_o     ),
    .feat_data_o      ( feat_data_o      ),
    .feat_ready_i     ( feat_ready_i     ),
    .weight_valid_o   ( weight_valid_o   ),
    .weight_data_o    ( weight_data_o    ),
    .weight_ready_i   ( weight_ready_i   ),
    .norm_valid_o     ( norm_valid_o     ),
    .norm_data_o      ( norm_data_o      ),
    .norm_ready_i     ( norm_ready_i     ),
    .streamin_valid_o ( streamin_valid_o ),
    .streamin_data_o  ( streamin_data_o  ),
    .streamin_ready_i ( streamin_ready_i )
  );

endmodule

// File: sim/streamer_tb_assert.sv
`timescale 1ns/10ps

module streamer_tb_assert (
  input logic                              clk_i,
  input logic                              rst_n_i,
  input logic                              busy_i,
  input logic                              done_i,
  input logic                              mem_req_i,
  input logic [3:0]                        valid_i,  // streamin, norm, weight, feat
  input logic [3:0]                        ready_i,
  input logic [4*streamer_pkg::DATA_W-1:0] data_i
);
  import streamer_pkg::*;

  int unsigned fail_cnt = 0;  // summed into the final verdict

  one_valid_a: assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(valid_i))
    else begin
      $error("more than one load stream valid");
      fail_cnt++;
    end

  idle_req_a: assert property (@(posedge clk_i) disable iff (!rst_n_i) !busy_i |-> !mem_req_i)
    else begin
      $error("memory request while not busy");
      fail_cnt++;
    end

  done_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_n_i) done_i |=> !done_i)
    else begin
      $error("done held longer than one cycle");
      fail_cnt++;
    end

  // valid and data hold until the handshake
  for (genvar k = 0; k < 4; k++) begin : g_hold
    hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      valid_i[k] && !ready_i[k] |=> valid_i[k] && $stable(data_i[k*DATA_W +: DATA_W]))
      else begin
        $error("stream %0d dropped valid or changed data before ready", k);
        fail_cnt++;
      end
  end

endmodule

bind streamer_top streamer_tb_assert u_assert (
  .clk_i     ( clk_i     ),
  .rst_n_i   ( rst_n_i   ),
  .busy_i    ( busy_o    ),
  .done_i    ( done_o    ),
  .mem_req_i ( mem_req_o ),
  .valid_i   ( {streamin_valid_o, norm_valid_o, weight_valid_o, feat_valid_o} ),
  .ready_i   ( {streamin_ready_i, norm_ready_i, weight_ready_i, feat_ready_i} ),
  .data_i    ( {streamin_data_o, norm_data_o, weight_data_o, feat_data_o} )
);

// File: sim/streamer_tb.sv
`timescale 1ns/10ps

module streamer_tb;
  import streamer_pkg::*;

  typedef struct {
    string             name;
    streamer_op_e      op;
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] stride;
    logic [LEN_W-1:0]  len;
    bit                bp;  // random stalls on the output streams
  } test_row_t;

  test_row_t tests [5] = '{
    '{"feat_s1",      OP_LD_FEAT,     16'h0100, 16'd1, 16'd12, 1'b0},
    '{"weight_s3_bp", OP_LD_WEIGHT,   16'h0400, 16'd3, 16'd20, 1'b1},
    '{"norm_s1",      OP_LD_NORM,     16'h0800, 16'd1, 16'd8,  1'b0},
    '{"streamin_s2",  OP_LD_STREAMIN, 16'h0900, 16'd2, 16'd8,  1'b1},
    '{"store_s2",     OP_ST_OUT,      16'h2000, 16'd2, 16'd10, 1'b0}
  };

  logic              clk_i, rst_n_i, start_i;
  streamer_op_e      op_i;
  logic [ADDR_W-1:0] base_i, stride_i, mem_addr_o;
  logic [LEN_W-1:0]  len_i;
  logic              busy_o, done_o, mem_req_o, mem_wen_o, mem_gnt_i, mem_rvalid_i;
  logic [DATA_W-1:0] mem_wdata_o, mem_rdata_i, st_data_i;
  logic              st_valid_i, st_ready_o;
  wire  [3:0]        valid;     // streamin, norm, weight, feat
  wire  [DATA_W-1:0] data [4];
  logic [3:0]        ready;

  // memory model and what it should hold
  logic [DATA_W-1:0] mem [65536];
  logic [DATA_W-1:0] exp_mem [65536];
  logic [DATA_W-1:0] rx_data [$];
  logic [31:0]       lcg_state = 32'h1b3bb266;
  logic              rv_next;
  logic [DATA_W-1:0] rd_next;
  int                cur_stream, stray_cnt, done_cnt, st_idx, st_len;
  bit                cur_bp, store_on;
  int                cycle_cnt = 0;
  int                cycle_limit = 100;
  int                err_total = 0;
  int                failed_tests = 0;

  streamer_top dut_i (
    .*,
    .feat_valid_o     ( valid[0] ),
    .feat_data_o      ( data[0]  ),
    .feat_ready_i     ( ready[0] ),
    .weight_valid_o   ( valid[1] ),
    .weight_data_o    ( data[1]  ),
    .weight_ready_i   ( ready[1] ),
    .norm_valid_o     ( valid[2] ),
    .norm_data_o      ( data[2]  ),
    .norm_ready_i     ( ready[2] ),
    .streamin_valid_o ( valid[3] ),
    .streamin_data_o  ( data[3]  ),
    .streamin_ready_i ( ready[3] )
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [DATA_W-1:0] init_word(input int a);
    return {a[15:0], a[15:0] ^ 16'hc35a};
  endfunction

  function automatic logic [DATA_W-1:0] store_word(input int i);
    return {16'hc0de, 16'(i * 7 + 3)};
  endfunction

  // the opcode picks the stream, stores use none
  function automatic int stream_of(input streamer_op_e op);
    case (op)
      OP_LD_FEAT:     return 0;
      OP_LD_WEIGHT:   return 1;
      OP_LD_NORM:     return 2;
      OP_LD_STREAMIN: return 3;
      default:        return -1;
    endcase
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, a job never finished", cycle_cnt);
      $display("Test FAILED");
      $finish;
    end
  end

  // one clock: sample at the edge, drive 1 ns later
  task automatic cycle_step();
    logic [31:0] r;
    int          k;
    @(posedge clk_i);
    rv_next = 1'b0;
    if (mem_req_o && mem_gnt_i) begin
      if (mem_wen_o) begin
        mem[mem_addr_o] = mem_wdata_o;
      end else begin
        rv_next = 1'b1;
        rd_next = mem[mem_addr_o];
      end
    end
    for (k = 0; k < 4; k++) begin
      if (valid[k] && k != cur_stream) stray_cnt++;
      if (valid[k] && ready[k]) rx_data.push_back(data[k]);
    end
    if (done_o) done_cnt++;
    if (st_valid_i && st_ready_o) st_idx++;
    #1;
    r            = lcg_next();
    mem_rvalid_i = rv_next;  // response one cycle after the grant
    mem_rdata_i  = rd_next;
    mem_gnt_i    = (r[31:30] != 2'b00);
    ready        = (cur_bp && r[27]) ? 4'b0000 : 4'b1111;
    st_valid_i   = store_on && (st_idx < st_len);
    st_data_i    = store_word(st_idx);
  endtask

  task automatic run_test(input int t);
    int errs;
    int i;
    int n;
    int a;
    errs       = 0;
    cur_stream = stream_of(tests[t].op);
    store_on   = (tests[t].op == OP_ST_OUT);
    cur_bp     = tests[t].bp;
    st_len     = tests[t].len;
    st_idx     = 0;
    stray_cnt  = 0;
    done_cnt   = 0;
    rx_data.delete();
    if (store_on) begin
      for (i = 0; i < tests[t].len; i++) begin
        exp_mem[16'(tests[t].base + i * tests[t].stride)] = store_word(i);
      end
    end
    op_i     = tests[t].op;
    base_i   = tests[t].base;
    stride_i = tests[t].stride;
    len_i    = tests[t].len;
    start_i  = 1'b1;
    cycle_step();
    assert (busy_o) else begin
      $display("%s: busy_o did not rise one cycle after start", tests[t].name);
      errs++;
    end
    start_i = 1'b0;
    cycle_step();
    start_i = 1'b1;  // extra start while busy, junk base
    base_i  = ~tests[t].base;
    cycle_step();
    start_i = 1'b0;
    while (done_cnt == 0) cycle_step();
    repeat (10) cycle_step();

    assert (done_cnt == 1) else begin
      $display("Error %s done pulses: expected 1, got %0d", tests[t].name, done_cnt);
      errs++;
    end
    assert (!busy_o) else begin
      $display("%s: busy_o still high after done", tests[t].name);
      errs++;
    end
    assert (stray_cnt == 0) else begin
      $display("%s: an unselected stream raised valid on %0d cycles", tests[t].name, stray_cnt);
      errs++;
    end
    n = store_on ? st_idx : rx_data.size();
    assert (n == tests[t].len) else begin
      $display("Error %s beats: expected %0d, got %0d", tests[t].name, tests[t].len, n);
      errs++;
    end
    for (i = 0; i < rx_data.size() && i < tests[t].len; i++) begin
      a = 16'(tests[t].base + i * tests[t].stride);
      assert (rx_data[i] == exp_mem[a]) else begin
        $display("Error %s word %0d: expected %h, got %h",
                 tests[t].name, i, exp_mem[a], rx_data[i]);
        errs++;
      end
    end
    for (a = 0; a < 65536; a++) begin
      assert (mem[a] === exp_mem[a]) else begin
        $display("Error %s mem[%h]: expected %h, got %h",
                 tests[t].name, a[15:0], exp_mem[a], mem[a]);
        errs++;
      end
    end
    $display("%s: %s, %0d errors", tests[t].name, (errs == 0) ? "passed" : "failed", errs);
    err_total += errs;
    if (errs != 0) failed_tests++;
  endtask

  initial begin
    int t;
    int a;
    rst_n_i      = 1'b0;
    start_i      = 1'b0;
    op_i         = OP_LD_FEAT;
    base_i       = '0;
    stride_i     = '0;
    len_i        = '0;
    mem_gnt_i    = 1'b0;
    mem_rdata_i  = '0;
    mem_rvalid_i = 1'b0;
    st_valid_i   = 1'b0;
    st_data_i    = '0;
    ready        = 4'b0000;
    cur_stream   = -1;
    cur_bp       = 1'b0;
    store_on     = 1'b0;
    st_len       = 0;
    st_idx       = 0;
    stray_cnt    = 0;
    done_cnt     = 0;
    rv_next      = 1'b0;
    rd_next      = '0;
    for (a = 0; a < 65536; a++) begin
      mem[a]     = init_word(a);
      exp_mem[a] = init_word(a);
    end
    for (t = 0; t < $size(tests); t++) cycle_limit += 40 * tests[t].len;

    repeat (3) cycle_step();
    rst_n_i = 1'b1;
    cycle_step();
    assert (!busy_o && !done_o && !mem_req_o && !st_ready_o && valid == 4'b0000) else begin
      $display("outputs not idle after reset");
      err_total++;
    end

    for (t = 0; t < $size(tests); t++) run_test(t);

    $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
             $size(tests), failed_tests, err_total, dut_i.u_assert.fail_cnt);
    if (err_total == 0 && dut_i.u_assert.fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
verilog/streamer_pkg.sv
verilog/mem_if.sv
verilog/streamer_ctrl.sv
verilog/req_gen.sv
verilog/load_buffer.sv
verilog/streamer_top.sv
sim/streamer_tb_assert.sv
sim/streamer_tb.sv

// File: Bender.yml
package:
  name: streamer

sources:
  - verilog/streamer_pkg.sv
  - verilog/mem_if.sv
  - verilog/streamer_ctrl.sv
  - verilog/req_gen.sv
  - verilog/load_buffer.sv
  - verilog/streamer_top.sv
  - target: test
    files:
      - sim/streamer_tb_assert.sv
      - sim/streamer_tb.sv
